//--- sim.f
rvPkg.sv
alu.sv
regFile.sv
mainDecoder.sv
aluDecoder.sv
dataPath.sv
riscvCore.sv
tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the status follows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb -o simTb \
    && ./obj_dir/simTb | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

//--- tb.sv
// self-checking testbench with its own isa model, memories hold 256 words and resetVector is zero
`timescale 1ns/1ps

module tb;

    localparam logic [31:0] resetVector = 32'h0;
    localparam int aluCount = 40;                        // random alu ops in one program
    localparam int progTotal = 2 + (15 + 2 * aluCount + 1) + 5 + 12 + 3 + 6;
    localparam int timeoutLimit = progTotal + 50;        // cycles with rstN high

    logic clk;
    logic rstN;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] pc;
    logic memWrite;
    logic [31:0] dataAdr;
    logic [31:0] writeData;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] mMem [256];   // model memory
    logic [31:0] mRegs [32];   // model registers
    logic [31:0] mPc;          // model pc
    logic [31:0] prog [$];
    logic [31:0] lcgState;
    logic checking;
    int cycles;
    int errors;                // in the current test
    int testsFailed;
    int testsPassed;
    int totalErrors;

    riscvCore #(.resetVector(resetVector)) dut0
    (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .memWrite  (memWrite),
        .dataAdr   (dataAdr),
        .writeData (writeData)
    );

    // memories read in the same cycle
    assign instr    = imem[pc[9:2]];
    assign readData = dmem[dataAdr[9:2]];

    always @(posedge clk)
    begin
        if (memWrite === 1'b1)
            dmem[dataAdr[9:2]] <= writeData;
    end

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // field packers for the formats used
    function automatic logic [31:0] rType(logic f7b5, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return iType(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    task automatic flagValue(string name, logic [31:0] expected, logic [31:0] actual);
        $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        errors++;
    endtask

    // one instruction of the reference isa after checking the DUT ports
    task automatic stepModel();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic [2:0] f3;
        logic wr;
        logic store;
        ins    = imem[mPc[9:2]];
        a      = mRegs[ins[19:15]];
        b      = mRegs[ins[24:20]];
        f3     = ins[14:12];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        nextPc = mPc + 32'd4;
        wr     = 1'b0;
        store  = 1'b0;
        res    = '0;
        if (ins[6:0] == 7'b0010011)
            b = immI;                                    // alu immediate form
        case (ins[6:0])
            7'b0110011, 7'b0010011:
            begin
                wr = 1'b1;
                case (f3)
                    3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b010: res = {31'b0, $signed(a) < $signed(b)};
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: wr = 1'b0;                  // not generated
                endcase
            end
            7'b0000011:
            begin
                wr  = 1'b1;
                res = mMem[(a + immI) >> 2];             // lw, word aligned
            end
            7'b0100011: store = 1'b1;
            7'b1100011:
                if (a == b)
                    nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            7'b1101111:
            begin
                wr     = 1'b1;
                res    = mPc + 32'd4;
                nextPc = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;                                   // illegal is a no-op
        endcase
        assert (pc === mPc) else flagValue("pc", mPc, pc);
        assert (memWrite === store) else flagValue("memWrite", {31'b0, store}, {31'b0, memWrite});
        if (store)
        begin
            assert (dataAdr === a + immS) else flagValue("dataAdr", a + immS, dataAdr);
            assert (writeData === b) else flagValue("writeData", b, writeData);
            mMem[(a + immS) >> 2] = b;
        end
        if (wr && ins[11:7] != 5'd0)
            mRegs[ins[11:7]] = res;
        mPc = nextPc;
    endtask

    // checks sit mid cycle where everything is settled
    always @(negedge clk)
    begin
        if (!rstN)
        begin
            assert (memWrite === 1'b0) else flagValue("memWrite", 32'h0, {31'b0, memWrite});
            if (checking)
                assert (pc === resetVector) else flagValue("pc", resetVector, pc);
            mPc = resetVector;
        end
        else if (checking)
        begin
            stepModel();
        end
    end

    always @(posedge clk)
    begin
        if (checking && rstN)
            cycles++;
        if (cycles > timeoutLimit)
        begin
            $display("timeout: the program did not reach its halt loop");
            $display("TB FAILED");
            $finish;
        end
    end

    // loads prog plus a halt loop, resets and runs until pc sits on the halt
    task automatic runProgram();
        logic [31:0] haltAdr;
        logic [31:0] fill;
        prog.push_back(jal(21'd0, 5'd0));
        haltAdr = 32'(4 * (prog.size() - 1));
        @(posedge clk);
        #1 rstN = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            fill    = 32'h5A5A0000 ^ (32'(i) * 32'h9E3779B1); // whole address matters
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
            dmem[i] <= fill;
            mMem[i] = fill;
        end
        @(posedge clk);                                  // first reset edge loads pc
        #1 checking = 1'b1;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        while (pc !== haltAdr)
        begin
            @(posedge clk);
            #1;
        end
        @(negedge clk);                                  // one check at the halt
        #1 checking = 1'b0;
        prog.delete();
    endtask

    task automatic checkWord(string name, int idx, logic [31:0] expected);
        assert (dmem[idx] === expected) else flagValue(name, expected, dmem[idx]);
    endtask

    task automatic finishTest(string name);
        if (errors == 0)
            testsPassed++;
        else
            testsFailed++;
        $display("test %s: %s with %0d errors", name, (errors == 0) ? "ok" : "bad", errors);
        totalErrors += errors;
        errors = 0;
    endtask

    initial
    begin
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        rstN = 1'b0;
        checking = 1'b0;
        lcgState = 32'h2683;
        cycles = 0;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        totalErrors = 0;
        for (int i = 0; i < 32; i++)
            mRegs[i] = '0;

        prog.push_back(sw(12'd0, 5'd0, 5'd0));           // store at reset vector tests gating
        runProgram();
        finishTest("reset");

        for (int i = 1; i < 16; i++)
            prog.push_back(addi(5'(i), 5'd0, 12'(lcg()))); // negatives included
        for (int i = 0; i < aluCount; i++)
        begin
            rd  = 5'(1 + lcg() % 15);
            rs1 = 5'(1 + lcg() % 15);
            rs2 = 5'(1 + lcg() % 15);
            imm = 12'(lcg());
            case (lcg() % 9)
                0: prog.push_back(rType(1'b0, rs2, rs1, 3'b000, rd));
                1: prog.push_back(rType(1'b1, rs2, rs1, 3'b000, rd));
                2: prog.push_back(rType(1'b0, rs2, rs1, 3'b111, rd));
                3: prog.push_back(rType(1'b0, rs2, rs1, 3'b110, rd));
                4: prog.push_back(rType(1'b0, rs2, rs1, 3'b010, rd));
                5: prog.push_back(iType(imm, rs1, 3'b000, rd, 7'b0010011));
                6: prog.push_back(iType(imm, rs1, 3'b111, rd, 7'b0010011));
                7: prog.push_back(iType(imm, rs1, 3'b110, rd, 7'b0010011));
                default: prog.push_back(iType(imm, rs1, 3'b010, rd, 7'b0010011));
            endcase
            prog.push_back(sw(12'(4 * i), rd, 5'd0));    // result out for checking
        end
        runProgram();
        finishTest("alu");

        prog.push_back(addi(5'd3, 5'd0, 12'h9C5));
        prog.push_back(sw(12'd64, 5'd3, 5'd0));
        prog.push_back(iType(12'd64, 5'd0, 3'b010, 5'd20, 7'b0000011)); // lw x20
        prog.push_back(sw(12'd68, 5'd20, 5'd0));
        runProgram();
        checkWord("dmem[17]", 17, 32'hFFFFF9C5);
        finishTest("loadStore");

        prog.push_back(addi(5'd1, 5'd0, 12'd5));         // 0
        prog.push_back(addi(5'd2, 5'd0, 12'd5));         // 4
        prog.push_back(addi(5'd3, 5'd0, 12'd7));         // 8
        prog.push_back(beq(13'd8, 5'd1, 5'd3));          // 12 not taken
        prog.push_back(beq(13'd8, 5'd1, 5'd2));          // 16 taken to 24
        prog.push_back(addi(5'd4, 5'd0, 12'd1));         // 20 skipped
        prog.push_back(jal(21'd12, 5'd5));               // 24 forward to 36
        prog.push_back(sw(12'd4, 5'd6, 5'd0));           // 28
        prog.push_back(jal(21'd12, 5'd0));               // 32 to halt at 44
        prog.push_back(sw(12'd0, 5'd5, 5'd0));           // 36
        prog.push_back(jal(-21'sd12, 5'd6));             // 40 backward to 28
        runProgram();
        checkWord("dmem[0]", 0, 32'd28);                 // link of jal at 24
        checkWord("dmem[1]", 1, 32'd44);                 // link of jal at 40
        finishTest("controlFlow");

        prog.push_back(addi(5'd0, 5'd0, 12'd123));
        prog.push_back(sw(12'd8, 5'd0, 5'd0));
        runProgram();
        checkWord("dmem[2]", 2, 32'd0);
        finishTest("x0");

        prog.push_back(addi(5'd31, 5'd0, 12'd9));
        prog.push_back(addi(5'd7, 5'd0, 12'd55));
        prog.push_back(32'hFFFFFFFF);                    // opcode 7f, rd would be x31
        prog.push_back(sw(12'd12, 5'd31, 5'd0));
        prog.push_back(sw(12'd16, 5'd7, 5'd0));
        runProgram();
        checkWord("dmem[3]", 3, 32'd9);
        checkWord("dmem[4]", 4, 32'd55);
        finishTest("illegal");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, totalErrors);
        if (testsFailed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- riscvCore.sv
// single-cycle rv32i subset core that expects instruction and data memories with same-cycle reads
`timescale 1ns/1ps

module riscvCore
#(
    parameter logic [rvPkg::xlen-1:0] resetVector = '0 // pc while in reset
)
(
    input  logic                   clk,
    input  logic                   rstN,      // sync active low
    input  logic [rvPkg::xlen-1:0] instr,     // from instruction memory at pc
    input  logic [rvPkg::xlen-1:0] readData,  // from data memory at dataAdr
    output logic [rvPkg::xlen-1:0] pc,
    output logic                   memWrite,  // store at rising edge
    output logic [rvPkg::xlen-1:0] dataAdr,
    output logic [rvPkg::xlen-1:0] writeData
);

    rvPkg::ctrlT     ctrl;     // control word
    rvPkg::aluClassT aluClass; // main to alu decoder
    rvPkg::aluOpT    aluOp;    // alu decoder to alu

    mainDecoder mainDecoder0
    (
        .op       (rvPkg::opcodeT'(instr[6:0])),
        .ctrl     (ctrl),
        .aluClass (aluClass)
    );

    aluDecoder aluDecoder0
    (
        .aluClass (aluClass),
        .funct3   (instr[14:12]),
        .opb5     (instr[5]),
        .funct7b5 (instr[30]),
        .aluOp    (aluOp)
    );

    dataPath
    #(
        .resetVector (resetVector)
    )
    dataPath0
    (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .ctrl      (ctrl),
        .aluOp     (aluOp),
        .readData  (readData),
        .pc        (pc),
        .memWrite  (memWrite),
        .dataAdr   (dataAdr),
        .writeData (writeData)
    );

endmodule

//--- dataPath.sv
// single-cycle data path with combinational memories at the ports and pc loaded with resetVector in reset
`timescale 1ns/1ps

module dataPath
#(
    parameter logic [rvPkg::xlen-1:0] resetVector = '0 // first fetch address
)
(
    input  logic                   clk,
    input  logic                   rstN,      // sync active low
    input  logic [rvPkg::xlen-1:0] instr,     // current instruction
    input  rvPkg::ctrlT            ctrl,      // from main decoder
    input  rvPkg::aluOpT           aluOp,     // from alu decoder
    input  logic [rvPkg::xlen-1:0] readData,  // data memory read
    output logic [rvPkg::xlen-1:0] pc,        // instruction address
    output logic                   memWrite,  // store strobe
    output logic [rvPkg::xlen-1:0] dataAdr,   // data memory address
    output logic [rvPkg::xlen-1:0] writeData  // store data
);

    logic [rvPkg::xlen-1:0] pcNext;    // pc for next cycle
    logic [rvPkg::xlen-1:0] pcPlus4;   // sequential pc and jal link
    logic [rvPkg::xlen-1:0] pcTarget;  // branch or jump target
    logic                   pcSrc;     // 1 takes pcTarget
    logic [rvPkg::xlen-1:0] immExt;    // sign extended immediate
    logic [rvPkg::xlen-1:0] srcA;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] rd2;       // rs2 value
    logic [rvPkg::xlen-1:0] aluResult;
    logic                   aluZero;
    logic [rvPkg::xlen-1:0] result;    // writeback value

    // pc register
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc <= resetVector; // hold while in reset
        end
        else
        begin
            pc <= pcNext;
        end
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt; // immSrc already picks B or J format
    assign pcSrc    = (ctrl.branch & aluZero) | ctrl.jump;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    // immediate extension for the four formats used
    always_comb
    begin
        case (ctrl.immSrc)
            rvPkg::immI:
                immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:20]};
            rvPkg::immS:
                immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB:
                immExt = {{(rvPkg::xlen-12){instr[31]}}, instr[7], instr[30:25],
                          instr[11:8], 1'b0};          // halfword aligned
            rvPkg::immJ:
                immExt = {{(rvPkg::xlen-20){instr[31]}}, instr[19:12], instr[20],
                          instr[30:21], 1'b0};
        endcase
    end

    regFile regFile0
    (
        .clk  (clk),
        .rstN (rstN),
        .we   (ctrl.regWrite),
        .ra1  (instr[19:15]), // rs1
        .ra2  (instr[24:20]), // rs2
        .wa   (instr[11:7]),  // rd
        .wd   (result),
        .rd1  (srcA),
        .rd2  (rd2)
    );

    assign srcB = ctrl.aluSrc ? immExt : rd2; // operand b mux

    alu alu0
    (
        .a    (srcA),
        .b    (srcB),
        .op   (aluOp),
        .y    (aluResult),
        .zero (aluZero)
    );

    // writeback select
    always_comb
    begin
        case (ctrl.resultSrc)
            rvPkg::resMem:
                result = readData;   // lw
            rvPkg::resPcPlus4:
                result = pcPlus4;    // jal link
            default:
                result = aluResult;  // alu ops and unused code
        endcase
    end

    // memory side
    assign dataAdr   = aluResult;
    assign writeData = rd2;
    assign memWrite  = ctrl.memWrite & rstN; // no stores during reset

endmodule

//--- aluDecoder.sv
// alu operation decode where funct3 codes outside the subset fall back to add and have no meaning
`timescale 1ns/1ps

module aluDecoder
(
    input  rvPkg::aluClassT aluClass, // from main decoder
    input  logic [2:0]      funct3,   // instr bits 14 to 12
    input  logic            opb5,     // opcode bit 5 set for R-type
    input  logic            funct7b5, // funct7 bit 5 set for sub
    output rvPkg::aluOpT    aluOp     // to the alu
);

    logic rtypeSub; // sub needs both bits since addi reuses bit 30 as immediate

    assign rtypeSub = funct7b5 & opb5;

    always_comb
    begin
        case (aluClass)
            rvPkg::classAdd:
                aluOp = rvPkg::aluAdd; // lw sw jal
            rvPkg::classSub:
                aluOp = rvPkg::aluSub; // beq
            rvPkg::classFunct:
            begin
                case (funct3)
                    3'b000:
                    begin
                        if (rtypeSub)
                            aluOp = rvPkg::aluSub; // sub
                        else
                            aluOp = rvPkg::aluAdd; // add addi
                    end
                    3'b010:
                        aluOp = rvPkg::aluSlt; // slt slti
                    3'b110:
                        aluOp = rvPkg::aluOr;  // or ori
                    3'b111:
                        aluOp = rvPkg::aluAnd; // and andi
                    default:
                        aluOp = rvPkg::aluAdd; // unsupported funct3
                endcase
            end
            default:
                aluOp = rvPkg::aluAdd; // unused class code
        endcase
    end

endmodule

//--- mainDecoder.sv
// purely combinational opcode decode where unknown opcodes become a no-op that only advances pc
`timescale 1ns/1ps

module mainDecoder
(
    input  rvPkg::opcodeT   op,       // instr bits 6 to 0
    output rvPkg::ctrlT     ctrl,     // control word for the data path
    output rvPkg::aluClassT aluClass  // class for the alu decoder
);

    always_comb
    begin
        // defaults give a harmless word
        ctrl           = '0;
        ctrl.immSrc    = rvPkg::immI;
        ctrl.resultSrc = rvPkg::resAlu;
        aluClass       = rvPkg::classAdd;

        case (op)
            rvPkg::opLoad:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;          // base plus offset
                ctrl.resultSrc = rvPkg::resMem; // load data to rd
            end
            rvPkg::opStore:
            begin
                ctrl.immSrc   = rvPkg::immS;    // split offset
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            rvPkg::opRtype:
            begin
                ctrl.regWrite = 1'b1;           // rs1 op rs2
                aluClass      = rvPkg::classFunct;
            end
            rvPkg::opItype:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;           // rs1 op imm
                aluClass      = rvPkg::classFunct;
            end
            rvPkg::opBranch:
            begin
                ctrl.immSrc = rvPkg::immB;
                ctrl.branch = 1'b1;
                aluClass    = rvPkg::classSub;  // zero flag means equal
            end
            rvPkg::opJal:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = rvPkg::immJ;
                ctrl.resultSrc = rvPkg::resPcPlus4; // link
                ctrl.jump      = 1'b1;
            end
            default: ; // illegal opcode keeps the harmless defaults so pc moves on
        endcase
    end

endmodule

//--- regFile.sv
// 32 by xlen register file with combinational reads where x0 reads zero and writes wait for rstN high
`timescale 1ns/1ps

module regFile
(
    input  logic                   clk,
    input  logic                   rstN, // writes blocked while low
    input  logic                   we,   // write enable
    input  logic [4:0]             ra1,  // rs1
    input  logic [4:0]             ra2,  // rs2
    input  logic [4:0]             wa,   // rd
    input  logic [rvPkg::xlen-1:0] wd,   // write data
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);

    logic [rvPkg::xlen-1:0] regs [32]; // storage with entry 0 never written

    // single write port on the rising edge
    always_ff @(posedge clk)
    begin
        if (rstN && we && (wa != 5'd0))
        begin
            regs[wa] <= wd;
        end
    end

    // x0 hardwired to zero on both read ports
    always_comb
    begin
        rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
        rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];
    end

endmodule

//--- alu.sv
// xlen wide alu for add sub and or slt where slt is signed and unused op codes give zero
`timescale 1ns/1ps

module alu
(
    input  logic [rvPkg::xlen-1:0] a,    // rs1
    input  logic [rvPkg::xlen-1:0] b,    // rs2 or immediate
    input  rvPkg::aluOpT           op,
    output logic [rvPkg::xlen-1:0] y,
    output logic                   zero  // y is all zeros
);

    logic lessThan; // signed compare result

    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            rvPkg::aluAdd:
                y = a + b;
            rvPkg::aluSub:
                y = a - b;                   // also beq compare
            rvPkg::aluAnd:
                y = a & b;
            rvPkg::aluOr:
                y = a | b;
            rvPkg::aluSlt:
                y = {{(rvPkg::xlen-1){1'b0}}, lessThan};
            default:
                y = '0;                      // codes outside the subset
        endcase
    end

    assign zero = (y == '0); // beq takes this

endmodule

//--- rvPkg.sv
// shared encodings for the rv32i subset core covering lw sw add sub and or slt addi andi ori slti beq jal only
package rvPkg;

    localparam int xlen = 32; // data and address width

    // major opcodes taken from instr bits 6 to 0
    typedef enum logic [6:0]
    {
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opRtype  = 7'b0110011, // add sub and or slt
        opItype  = 7'b0010011, // addi andi ori slti
        opBranch = 7'b1100011, // beq
        opJal    = 7'b1101111  // jal
    } opcodeT;

    // coarse alu class handed from main decoder to alu decoder
    typedef enum logic [1:0]
    {
        classAdd   = 2'b00, // address calc and jal
        classSub   = 2'b01, // beq compare
        classFunct = 2'b10  // look at funct3 and funct7
    } aluClassT;

    // alu operation select
    typedef enum logic [2:0]
    {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101  // signed less than
    } aluOpT;

    // immediate format select
    typedef enum logic [1:0]
    {
        immI = 2'b00, // loads and alu immediates
        immS = 2'b01, // stores
        immB = 2'b10, // branches
        immJ = 2'b11  // jal
    } immSrcT;

    // writeback source select
    typedef enum logic [1:0]
    {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10  // link value for jal
    } resultSrcT;

    // control word from main decoder to data path
    typedef struct packed
    {
        logic      regWrite;  // write rd at clock edge
        immSrcT    immSrc;    // immediate format
        logic      aluSrc;    // 1 selects immediate as alu operand b
        logic      memWrite;  // store at clock edge
        resultSrcT resultSrc; // writeback mux
        logic      branch;    // beq
        logic      jump;      // jal
    } ctrlT;

endpackage
